//--- hw/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

	localparam int SHADER_LANES = 4;
	localparam int FPINT_STAGES = 4;
	localparam int FLOAT_BIAS = 127;

	// One lane word, read either as a single float or as a signed integer.
	typedef union packed {
		struct packed {
			logic        sign;
			logic [7:0]  exponent;
			logic [22:0] mantissa;
		} f;
		logic signed [31:0] i;
	} word;

	typedef enum logic [1:0] {
		OP_ITOF,
		OP_FTOI,
		OP_FMIN,
		OP_FMAX
	} fpint_opcode;

	typedef struct packed {
		logic unpack_float;   // Stage 0.
		logic minmax_enable;  // Stage 1.
		logic minmax_max;
		logic norm_enable;    // Stage 2.
		logic shiftr_enable;
		logic encode_float;   // Stage 3.
	} fpint_op;

	localparam word CANON_NAN = 32'h7fc0_0000;

	localparam logic signed [31:0] INT_MAX_SAT = 32'sh7fff_ffff;
	localparam logic signed [31:0] INT_MIN_SAT = 32'sh8000_0000;

endpackage

`default_nettype wire

//--- hw/gfx_fpint_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface gfx_fpint_ctrl_if;

	logic unpack_float;   // Read by stage 0.
	logic minmax_enable;  // Read by stage 1.
	logic minmax_max;
	logic norm_enable;    // Read by stage 2.
	logic shiftr_enable;
	logic encode_float;   // Read by stage 3.

	modport ctrl (
		output unpack_float, minmax_enable, minmax_max,
		output norm_enable, shiftr_enable, encode_float
	);

	modport lane (
		input unpack_float, minmax_enable, minmax_max,
		input norm_enable, shiftr_enable, encode_float
	);

endinterface

`default_nettype wire

//--- hw/gfx_fpint_norm.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_fpint_norm (
	input  logic [31:0] mag,
	output logic [22:0] mant,
	output logic [4:0]  lz,
	output logic        zero
);

	logic [31:0] s16;
	logic [31:0] s8;
	logic [31:0] s4;
	logic [31:0] s2;
	logic [31:0] s1;

	// Binary search where each step both counts and shifts.
	always_comb begin
		lz[4] = ~|mag[31:16];
		s16 = lz[4] ? {mag[15:0], 16'd0} : mag;

		lz[3] = ~|s16[31:24];
		s8 = lz[3] ? {s16[23:0], 8'd0} : s16;

		lz[2] = ~|s8[31:28];
		s4 = lz[2] ? {s8[27:0], 4'd0} : s8;

		lz[1] = ~|s4[31:30];
		s2 = lz[1] ? {s4[29:0], 2'd0} : s4;

		lz[0] = ~s2[31];
		s1 = lz[0] ? {s2[30:0], 1'b0} : s2;
	end

	// Leading one at bit 31 is the hidden bit.
	assign mant = s1[30:8];  // Truncated.
	assign zero = ~s1[31];

endmodule

`default_nettype wire

//--- hw/gfx_fpint_lane.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_fpint_lane (
	input  logic           clk,
	gfx_fpint_ctrl_if.lane ctrl,
	input  gfx_pkg::word   a,
	input  gfx_pkg::word   b,
	output gfx_pkg::word   q
);

	// Stage 0.
	gfx_pkg::word s0_a;
	gfx_pkg::word s0_b;
	logic         s0_sign;
	logic [31:0]  s0_mag;
	logic [7:0]   s0_exp;

	// Stage 1.
	gfx_pkg::word s1_res;
	logic         s1_sign;
	logic [31:0]  s1_mag;
	logic [5:0]   s1_shift;
	logic         s1_sat;

	// Stage 2.
	logic         s2_sign;
	logic [7:0]   s2_exp;
	logic [22:0]  s2_mant;
	logic [31:0]  s2_int;
	logic         s2_sat;

	gfx_pkg::word pick;
	logic         a_nan;
	logic         b_nan;
	logic         a_below;

	logic [22:0]  norm_mant;
	logic [4:0]   norm_lz;
	logic         norm_zero;

	function automatic logic is_nan(gfx_pkg::word w);
		return (&w.f.exponent) && (|w.f.mantissa);
	endfunction

	// Maps float bits onto an unsigned key with the same ordering.
	function automatic logic [31:0] order_key(gfx_pkg::word w);
		return w.f.sign ? ~w.i : {1'b1, w.i[30:0]};
	endfunction

	always_ff @(posedge clk) begin
		s0_a <= a;
		s0_b <= b;
		s0_sign <= a.f.sign;
		s0_exp <= a.f.exponent;
		if (ctrl.unpack_float) begin
			// Left aligned with denormals flushed to zero.
			s0_mag <= (a.f.exponent != 8'd0) ? {1'b1, a.f.mantissa, 8'd0} : 32'd0;
		end else begin
			s0_mag <= a.i[31] ? -a.i : a.i;
		end
	end

	assign a_nan = is_nan(s0_a);
	assign b_nan = is_nan(s0_b);
	assign a_below = order_key(s0_a) < order_key(s0_b);

	always_comb begin
		if (a_nan && b_nan)
			pick = gfx_pkg::CANON_NAN;
		else if (a_nan)
			pick = s0_b;
		else if (b_nan)
			pick = s0_a;
		else if (a_below ^ ctrl.minmax_max)
			pick = s0_a;
		else
			pick = s0_b;
	end

	always_ff @(posedge clk) begin
		s1_sign <= s0_sign;
		s1_mag <= s0_mag;
		s1_sat <= s0_exp >= 8'(gfx_pkg::FLOAT_BIAS + 31);
		if (s0_exp < 8'(gfx_pkg::FLOAT_BIAS))
			s1_shift <= 6'd32;  // Below one.
		else
			s1_shift <= 6'(gfx_pkg::FLOAT_BIAS + 31 - int'(s0_exp));
		if (ctrl.minmax_enable)
			s1_res <= pick;
	end

	gfx_fpint_norm norm (
		.mag  (s1_mag),
		.mant (norm_mant),
		.lz   (norm_lz),
		.zero (norm_zero)
	);

	always_ff @(posedge clk) begin
		if (ctrl.norm_enable) begin
			s2_sign <= s1_sign;
			s2_exp <= norm_zero ? 8'd0 : 8'(gfx_pkg::FLOAT_BIAS + 31 - int'(norm_lz));
			s2_mant <= norm_mant;
		end else if (ctrl.shiftr_enable) begin
			s2_sign <= s1_sign;
			s2_int <= s1_mag >> s1_shift;
			s2_sat <= s1_sat;  // Covers NaN and infinity too.
		end else begin
			s2_sign <= s1_res.f.sign;
			s2_exp <= s1_res.f.exponent;
			s2_mant <= s1_res.f.mantissa;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.encode_float) begin
			q.f.sign <= s2_sign;
			q.f.exponent <= s2_exp;
			q.f.mantissa <= s2_mant;
		end else if (s2_sat) begin
			q.i <= s2_sign ? gfx_pkg::INT_MIN_SAT : gfx_pkg::INT_MAX_SAT;
		end else begin
			q.i <= s2_sign ? -s2_int : s2_int;
		end
	end

endmodule

`default_nettype wire

//--- hw/gfx_fpint.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_fpint #(
	parameter int lanes = gfx_pkg::SHADER_LANES
) (
	input  logic                clk,
	input  logic                rst_n,

	input  logic                in_valid,
	input  gfx_pkg::fpint_opcode opcode,
	input  gfx_pkg::word        a[lanes],
	input  gfx_pkg::word        b[lanes],

	output logic                out_valid,
	output gfx_pkg::word        q[lanes]
);

	gfx_pkg::fpint_op op;
	gfx_pkg::fpint_op stage_op[1:gfx_pkg::FPINT_STAGES-1];
	logic             stage_valid[1:gfx_pkg::FPINT_STAGES-1];

	gfx_fpint_ctrl_if ctrl_bus ();

	always_comb begin
		op = '0;
		case (opcode)
			gfx_pkg::OP_ITOF: begin
				op.norm_enable = 1'b1;
				op.encode_float = 1'b1;
			end
			gfx_pkg::OP_FTOI: begin
				op.unpack_float = 1'b1;
				op.shiftr_enable = 1'b1;
			end
			gfx_pkg::OP_FMIN: begin
				op.unpack_float = 1'b1;
				op.minmax_enable = 1'b1;
				op.encode_float = 1'b1;
			end
			gfx_pkg::OP_FMAX: begin
				op.unpack_float = 1'b1;
				op.minmax_enable = 1'b1;
				op.minmax_max = 1'b1;
				op.encode_float = 1'b1;
			end
			default: op = '0;
		endcase
	end

	// Each control bit comes from the stage that feeds its lane register.
	assign ctrl_bus.unpack_float = op.unpack_float;
	assign ctrl_bus.minmax_enable = stage_op[1].minmax_enable;
	assign ctrl_bus.minmax_max = stage_op[1].minmax_max;
	assign ctrl_bus.norm_enable = stage_op[2].norm_enable;
	assign ctrl_bus.shiftr_enable = stage_op[2].shiftr_enable;
	assign ctrl_bus.encode_float = stage_op[3].encode_float;

	always_ff @(posedge clk) begin
		stage_op[1] <= op;
		for (int i = 2; i < gfx_pkg::FPINT_STAGES; i++)
			stage_op[i] <= stage_op[i - 1];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < gfx_pkg::FPINT_STAGES; i++)
				stage_valid[i] <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			stage_valid[1] <= in_valid;
			for (int i = 2; i < gfx_pkg::FPINT_STAGES; i++)
				stage_valid[i] <= stage_valid[i - 1];
			out_valid <= stage_valid[gfx_pkg::FPINT_STAGES-1];  // Lines up with q.
		end
	end

	for (genvar ln = 0; ln < lanes; ln++) begin : lane_gen
		gfx_fpint_lane lane_unit (
			.clk  (clk),
			.ctrl (ctrl_bus.lane),
			.a    (a[ln]),
			.b    (b[ln]),
			.q    (q[ln])
		);
	end

endmodule

`default_nettype wire

//--- sim/gfx_fpint_sva.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_fpint_sva (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 in_valid,
	input gfx_pkg::fpint_opcode opcode,
	input logic                 out_valid
);

	localparam int DEPTH = gfx_pkg::FPINT_STAGES;

	reset_clears_valid: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high while in reset");

	// Fixed latency with gaps included.
	valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, DEPTH))
		else $error("out_valid does not follow in_valid by %0d cycles", DEPTH);

	opcode_known: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !$isunknown(opcode))
		else $error("opcode unknown on an accepted item");

endmodule

bind gfx_fpint gfx_fpint_sva valid_checks (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.opcode    (opcode),
	.out_valid (out_valid)
);

`default_nettype wire

//--- sim/gfx_fpint_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_fpint_tb;

	localparam int LANES = 4;
	localparam int RANDOM_ITEMS = 2000;
	localparam int DIRECTED_ITEMS = 32;
	localparam int TIMEOUT_CYCLES = (RANDOM_ITEMS + DIRECTED_ITEMS) * 2 + 20;

	typedef gfx_pkg::word [LANES-1:0] lane_set;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	gfx_pkg::fpint_opcode opcode;
	gfx_pkg::word         a[LANES];
	gfx_pkg::word         b[LANES];
	logic                 out_valid;
	gfx_pkg::word         q[LANES];

	lane_set     exp_q[$];
	int          in_count = 0;
	int          out_count = 0;
	int          cycles = 0;
	logic [31:0] rng_state = 32'd91173;

	gfx_fpint #(.lanes(LANES)) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.opcode    (opcode),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.q         (q)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic logic is_float_nan(gfx_pkg::word w);
		return w.f.exponent == 8'hff && w.f.mantissa != 23'd0;
	endfunction

	// Strict float ordering. Minus zero sits below plus zero.
	function automatic logic float_below(gfx_pkg::word x, gfx_pkg::word y);
		if (x.f.sign != y.f.sign)
			return x.f.sign;
		if (x.f.sign)
			return x.i[30:0] > y.i[30:0];
		return x.i[30:0] < y.i[30:0];
	endfunction

	function automatic gfx_pkg::word int_to_float(gfx_pkg::word x);
		gfx_pkg::word r;
		logic [31:0]  mag;
		int           top;
		r.i = 32'sd0;
		mag = x.i[31] ? ~x.i + 32'd1 : x.i;
		if (mag == 32'd0)
			return r;
		top = 31;
		while (!mag[top])
			top--;
		r.f.sign = x.i[31];
		r.f.exponent = 8'(127 + top);
		r.f.mantissa = 23'((mag << (31 - top)) >> 8);  // Hidden bit dropped.
		return r;
	endfunction

	function automatic gfx_pkg::word float_to_int(gfx_pkg::word x);
		gfx_pkg::word r;
		logic [63:0]  mant;
		int           e;
		e = int'(x.f.exponent) - 127;
		if (e < 0) begin
			r.i = 32'sd0;
		end else if (e >= 31) begin
			r.i = x.f.sign ? gfx_pkg::INT_MIN_SAT : gfx_pkg::INT_MAX_SAT;
		end else begin
			mant = {40'd0, 1'b1, x.f.mantissa};
			mant = (e >= 23) ? mant << (e - 23) : mant >> (23 - e);
			r.i = x.f.sign ? -$signed(mant[31:0]) : $signed(mant[31:0]);
		end
		return r;
	endfunction

	function automatic gfx_pkg::word fpint_model(gfx_pkg::fpint_opcode op,
			gfx_pkg::word x, gfx_pkg::word y);
		gfx_pkg::word r;
		logic         take_x;
		if (op == gfx_pkg::OP_ITOF) begin
			r = int_to_float(x);
		end else if (op == gfx_pkg::OP_FTOI) begin
			r = float_to_int(x);
		end else if (is_float_nan(x) && is_float_nan(y)) begin
			r = gfx_pkg::CANON_NAN;
		end else if (is_float_nan(x) || is_float_nan(y)) begin
			r = is_float_nan(x) ? y : x;
		end else begin
			take_x = (op == gfx_pkg::OP_FMIN) ? float_below(x, y) : float_below(y, x);
			r = take_x ? x : y;
		end
		return r;
	endfunction

	function automatic gfx_pkg::word corner_value(int idx);
		gfx_pkg::word w;
		case (idx)
			1: w = 32'h8000_0000;  // Minus zero or INT_MIN.
			2: w = 32'h7fc0_0000;
			3: w = 32'h7f80_0000;
			4: w = 32'h4f00_0000;  // 2^31.
			5: w = 32'h3f00_0000;
			6: w = 32'hbfc0_0000;
			7: w = 32'hffff_ffff;  // Negative NaN or -1.
			default: w = 32'h0000_0000;
		endcase
		return w;
	endfunction

	function automatic gfx_pkg::word random_operand();
		logic [31:0]  r;
		logic [31:0]  pick;
		gfx_pkg::word w;
		r = xorshift32();
		pick = xorshift32();
		w.i = r;
		case (pick[1:0])
			2'd1: w.f.exponent = 8'd110 + 8'(pick[7:2]);  // Near the FTOI range.
			2'd2: w.i = $signed(r) >>> pick[6:2];
			2'd3: if (pick[8]) w.f.exponent = 8'hff;
			default: ;
		endcase
		return w;
	endfunction

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_word(int lane, gfx_pkg::word got, gfx_pkg::word want);
		if (got !== want) begin
			$display("ERROR %0t: lane %0d result %08h, expected %08h", $time, lane, got, want);
			abort_run();
		end
	endtask

	task automatic check_count(int accepted, int produced, logic at_end);
		if (produced > accepted) begin
			$display("out_valid came with no item in flight (%0d results for %0d items)",
				produced, accepted);
			abort_run();
		end else if (at_end && produced != accepted) begin
			$display("%0d of %0d items never left the pipeline", accepted - produced, accepted);
			abort_run();
		end
	endtask

	task automatic drive_item(gfx_pkg::fpint_opcode op, lane_set va, lane_set vb);
		lane_set want;
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		opcode = op;
		for (int ln = 0; ln < LANES; ln++) begin
			a[ln] = va[ln];
			b[ln] = vb[ln];
			want[ln] = fpint_model(op, va[ln], vb[ln]);
		end
		exp_q.push_back(want);
		in_count++;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	always @(negedge clk) begin
		lane_set want;
		if (out_valid) begin
			out_count++;
			check_count(in_count, out_count, 1'b0);
			want = exp_q.pop_front();
			for (int ln = 0; ln < LANES; ln++)
				check_word(ln, q[ln], want[ln]);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	initial begin
		lane_set              va;
		lane_set              vb;
		logic [31:0]          r;
		in_valid = 1'b0;
		opcode = gfx_pkg::OP_ITOF;
		for (int ln = 0; ln < LANES; ln++) begin
			a[ln] = '0;
			b[ln] = '0;
		end
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;

		// Eight pairings per opcode with both NaN and both zero orders.
		for (int k = 0; k < DIRECTED_ITEMS; k++) begin
			for (int ln = 0; ln < LANES; ln++) begin
				va[ln] = corner_value((k + ln) % 8);
				vb[ln] = corner_value((k + 3 * ln + 1) % 8);
			end
			drive_item(gfx_pkg::fpint_opcode'(2'(k / 8)), va, vb);
		end

		for (int k = 0; k < RANDOM_ITEMS; k++) begin
			r = xorshift32();
			if (r[1:0] == 2'd0)
				drive_idle();
			for (int ln = 0; ln < LANES; ln++) begin
				va[ln] = random_operand();
				vb[ln] = random_operand();
			end
			drive_item(gfx_pkg::fpint_opcode'(r[3:2]), va, vb);
		end
		drive_idle();

		repeat (gfx_pkg::FPINT_STAGES + 8) @(negedge clk);  // Drain and watch for strays.
		check_count(in_count, out_count, 1'b1);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
hw/gfx_pkg.sv
hw/gfx_fpint_ctrl_if.sv
hw/gfx_fpint_norm.sv
hw/gfx_fpint_lane.sv
hw/gfx_fpint.sv
sim/gfx_fpint_sva.sv
sim/gfx_fpint_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the FP/INT conversion testbench with Verilator.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module gfx_fpint_tb \
	-f compile.f -o gfx_fpint_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/gfx_fpint_sim > sim.log 2>&1
cat sim.log
grep -q "^Done: no errors$" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
